/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and address split
  ////////////////////////////////////////////////////////////////////////////
  localparam int ADDR_W      = 16;                    // Word addresses
  localparam int DATA_W      = 16;                    // One word per access
  localparam int OFFSET_W    = 2;                     // Word within block
  localparam int BLOCK_WORDS = 4;
  localparam int INDEX_W     = 3;                     // Set select
  localparam int SETS        = 8;
  localparam int TAG_W       = 11;                    // Upper address bits

  // Address is laid out as {tag, index, offset}
  localparam int INDEX_LSB   = OFFSET_W;
  localparam int TAG_LSB     = OFFSET_W + INDEX_W;
  localparam int BASE_W      = ADDR_W - OFFSET_W;     // Block base, no offset

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  ////////////////////////////////////////////////////////////////////////////
  // Request bundles
  ////////////////////////////////////////////////////////////////////////////
  // Cache side request, wr low for a read
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  wr;
  } cache_req_t;

  // Off-chip port, 34 bits
  typedef struct packed {
    logic  en;     // Access strobe, held for a whole read
    logic  wr;     // Write, completes in the issue cycle
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // Block fill sequencing
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_REQ,
    FILL_DONE
  } fill_state_t;

endpackage

`default_nettype wire

/* verilog/cache_array.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_array import mem_pkg::*; (
  input  wire          clk,
  input  wire          arst_n,
  input  wire addr_t   lookup_addr,   // Address of the request in front of the cache
  output logic         hit,
  output word_t        rdata,         // Word at lookup_addr, meaningful on hit
  input  wire          wr_en,         // Write hit, one word
  input  wire word_t   wr_data,
  input  wire          fill_we,       // One word of a block fill
  input  wire offset_t fill_offset,
  input  wire word_t   fill_data,
  input  wire          fill_last      // Final fill word, block becomes valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////
  tag_t            tag_mem  [SETS];
  word_t           data_mem [SETS][BLOCK_WORDS];
  logic [SETS-1:0] valid_q;                       // One bit per set

  tag_t    lk_tag;
  index_t  lk_index;
  offset_t lk_offset;

  // Split the lookup address
  assign lk_tag    = lookup_addr[ADDR_W-1:TAG_LSB];
  assign lk_index  = lookup_addr[TAG_LSB-1:INDEX_LSB];
  assign lk_offset = lookup_addr[OFFSET_W-1:0];

  // Direct mapped, so a single compare
  assign hit   = valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
  assign rdata = data_mem[lk_index][lk_offset];  // Read is combinational

  ////////////////////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;                              // Cache starts empty
    end else if (fill_we && fill_last) begin
      valid_q[lk_index] <= 1'b1;                  // Block complete
    end
  end

  // Tag and data, written at the next edge
  always_ff @(posedge clk) begin
    if (fill_we) begin
      data_mem[lk_index][fill_offset] <= fill_data;   // Fill walks the offsets
      if (fill_last) begin
        tag_mem[lk_index] <= lk_tag;                  // New owner of the set
      end
    end else if (wr_en) begin
      // Write hit replaces one word, the rest of the block stays
      data_mem[lk_index][lk_offset] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/cache_fill_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_fill_fsm import mem_pkg::*; (
  input  wire          clk,
  input  wire          arst_n,
  input  wire          miss,          // Valid request without a hit
  input  wire addr_t   miss_addr,
  output logic         fill_req,      // Asks the arbiter for the memory port
  input  wire          fill_grant,
  output addr_t        fill_addr,     // Word currently being read
  input  wire          fill_rvalid,   // Shared return strobe, gated by grant
  input  wire word_t   fill_rdata,
  output logic         fill_we,       // Array write strobes
  output offset_t      fill_offset,
  output word_t        fill_data,
  output logic         fill_last
);

  fill_state_t         state_q;
  fill_state_t         state_d;
  offset_t             cnt_q;         // Word within the block
  logic [BASE_W-1:0]   base_q;        // Block base of the miss

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////
  assign fill_req  = (state_q == FILL_REQ);
  assign fill_addr = {base_q, cnt_q};             // Base plus word counter

  // Only our own returned words count
  assign fill_we     = fill_req && fill_grant && fill_rvalid;
  assign fill_offset = cnt_q;
  assign fill_data   = fill_rdata;
  assign fill_last   = fill_we && (cnt_q == offset_t'(BLOCK_WORDS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      FILL_IDLE: begin
        if (miss) begin
          state_d = FILL_REQ;                     // Start the block read
        end
      end
      FILL_REQ: begin
        if (fill_last) begin
          state_d = FILL_DONE;
        end
      end
      FILL_DONE: state_d = FILL_IDLE;             // One cycle, array settles
      default:   state_d = FILL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= FILL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FILL_IDLE) begin
        cnt_q <= '0;                              // Always start at word 0
      end else if (fill_we) begin
        cnt_q <= cnt_q + 1'b1;                    // Next word after each return
      end
    end
  end

  // Base latched once, requester holds the address anyway
  always_ff @(posedge clk) begin
    if (state_q == FILL_IDLE && miss) begin
      base_q <= miss_addr[ADDR_W-1:OFFSET_W];
    end
  end

  // Memory sees one read address until that word comes back
  a_fill_addr_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    (fill_req && !fill_we) |=> $stable(fill_addr)
  );

endmodule

`default_nettype wire

/* verilog/cache_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_unit import mem_pkg::*; (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             req_valid,
  input  wire cache_req_t req,
  output logic            ready,          // Handshake, rdata valid with it
  output word_t           rdata,
  output logic            fill_req,       // To the arbiter
  input  wire             fill_grant,
  output addr_t           fill_addr,
  input  wire             fill_rvalid,
  input  wire word_t      fill_rdata,
  output logic            wt_req,         // Write-through toward memory
  output addr_t           wt_addr,
  output word_t           wt_data,
  input  wire             wt_ack
);

  logic    hit;
  logic    miss;
  logic    wr_en;
  logic    fill_we;
  offset_t fill_offset;
  word_t   fill_data;
  logic    fill_last;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////
  assign miss    = req_valid && !hit;             // Write miss fills first too
  assign wt_req  = req_valid && req.wr && hit;
  assign wt_addr = req.addr;
  assign wt_data = req.wdata;
  assign wr_en   = wt_req && wt_ack;              // Array and memory in step

  // Reads finish on the hit, writes also need the port
  assign ready = req_valid && hit && (!req.wr || wt_ack);

  cache_array i_array (
    .clk         (clk),
    .arst_n      (arst_n),
    .lookup_addr (req.addr),
    .hit         (hit),
    .rdata       (rdata),
    .wr_en       (wr_en),
    .wr_data     (req.wdata),
    .fill_we     (fill_we),
    .fill_offset (fill_offset),
    .fill_data   (fill_data),
    .fill_last   (fill_last)
  );

  cache_fill_fsm i_fill (
    .clk         (clk),
    .arst_n      (arst_n),
    .miss        (miss),
    .miss_addr   (req.addr),
    .fill_req    (fill_req),
    .fill_grant  (fill_grant),
    .fill_addr   (fill_addr),
    .fill_rvalid (fill_rvalid),
    .fill_rdata  (fill_rdata),
    .fill_we     (fill_we),
    .fill_offset (fill_offset),
    .fill_data   (fill_data),
    .fill_last   (fill_last)
  );

  // The fill indexes by the live request, so it must not move
  a_req_held : assert property (
    @(posedge clk) disable iff (!arst_n)
    (req_valid && !ready) |=> (req_valid && $stable(req))
  );

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         i_fill_req,       // Instruction cache fill
  input  wire addr_t  i_fill_addr,
  output logic        i_grant,
  input  wire         d_fill_req,       // Data cache fill
  input  wire addr_t  d_fill_addr,
  output logic        d_grant,
  input  wire         d_wt_req,         // Data write-through
  input  wire addr_t  d_wt_addr,
  input  wire word_t  d_wt_data,
  output logic        d_wt_ack,
  output mem_req_t    mem_req,          // Off-chip port
  input  wire         mem_data_valid,
  input  wire word_t  mem_rdata,
  output logic        fill_rvalid,      // Returned to both caches
  output word_t       fill_rdata
);

  logic busy;

  ////////////////////////////////////////////////////////////////////////////
  // Grant lock, one fill at a time
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      i_grant <= 1'b0;
      d_grant <= 1'b0;
    end else if (i_grant) begin
      if (!i_fill_req) begin
        i_grant <= 1'b0;                          // FSM left FILL_REQ
      end
    end else if (d_grant) begin
      if (!d_fill_req) begin
        d_grant <= 1'b0;
      end
    end else if (i_fill_req) begin
      i_grant <= 1'b1;                            // Instruction side wins a tie
    end else if (d_fill_req) begin
      d_grant <= 1'b1;
    end
  end

  assign busy     = i_grant || d_grant;
  assign d_wt_ack = d_wt_req && !busy;            // Writes slot in between fills

  // Port mux, en drops as soon as the owner stops asking
  always_comb begin
    mem_req = '0;
    if (i_grant) begin
      mem_req.en   = i_fill_req;
      mem_req.addr = i_fill_addr;
    end else if (d_grant) begin
      mem_req.en   = d_fill_req;
      mem_req.addr = d_fill_addr;
    end else if (d_wt_ack) begin
      mem_req.en    = 1'b1;
      mem_req.wr    = 1'b1;
      mem_req.addr  = d_wt_addr;
      mem_req.wdata = d_wt_data;
    end
  end

  // Each FSM qualifies this with its own grant
  assign fill_rvalid = mem_data_valid;
  assign fill_rdata  = mem_rdata;

  a_grant_onehot : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(i_grant && d_grant)
  );

  // A write never lands inside a block read
  a_wr_idle : assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_req.wr |-> (mem_req.en && !busy)
  );

endmodule

`default_nettype wire

/* verilog/mem_hier_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_hier_top import mem_pkg::*; (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             i_req_valid,      // Instruction fetch side
  input  wire addr_t      i_req_addr,
  output logic            i_ready,
  output word_t           i_rdata,
  input  wire             d_req_valid,      // Load/store side
  input  wire cache_req_t d_req,
  output logic            d_ready,
  output word_t           d_rdata,
  output mem_req_t        mem_req,          // Shared off-chip port
  input  wire             mem_data_valid,
  input  wire word_t      mem_rdata
);

  cache_req_t i_req;              // Fetches never write
  logic       i_fill_req;
  logic       i_fill_grant;
  addr_t      i_fill_addr;
  logic       d_fill_req;
  logic       d_fill_grant;
  addr_t      d_fill_addr;
  logic       fill_rvalid;
  word_t      fill_rdata;
  logic       d_wt_req;
  addr_t      d_wt_addr;
  word_t      d_wt_data;
  logic       d_wt_ack;

  assign i_req = '{addr: i_req_addr, wdata: '0, wr: 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Caches
  ////////////////////////////////////////////////////////////////////////////
  cache_unit i_icache (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (i_req_valid),
    .req         (i_req),
    .ready       (i_ready),
    .rdata       (i_rdata),
    .fill_req    (i_fill_req),
    .fill_grant  (i_fill_grant),
    .fill_addr   (i_fill_addr),
    .fill_rvalid (fill_rvalid),
    .fill_rdata  (fill_rdata),
    .wt_req      (),                // Read only, no write-through
    .wt_addr     (),
    .wt_data     (),
    .wt_ack      (1'b0)
  );

  cache_unit i_dcache (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (d_req_valid),
    .req         (d_req),
    .ready       (d_ready),
    .rdata       (d_rdata),
    .fill_req    (d_fill_req),
    .fill_grant  (d_fill_grant),
    .fill_addr   (d_fill_addr),
    .fill_rvalid (fill_rvalid),
    .fill_rdata  (fill_rdata),
    .wt_req      (d_wt_req),
    .wt_addr     (d_wt_addr),
    .wt_data     (d_wt_data),
    .wt_ack      (d_wt_ack)
  );

  // Port sharing between the two
  mem_arbiter i_arb (
    .clk            (clk),
    .arst_n         (arst_n),
    .i_fill_req     (i_fill_req),
    .i_fill_addr    (i_fill_addr),
    .i_grant        (i_fill_grant),
    .d_fill_req     (d_fill_req),
    .d_fill_addr    (d_fill_addr),
    .d_grant        (d_fill_grant),
    .d_wt_req       (d_wt_req),
    .d_wt_addr      (d_wt_addr),
    .d_wt_data      (d_wt_data),
    .d_wt_ack       (d_wt_ack),
    .mem_req        (mem_req),
    .mem_data_valid (mem_data_valid),
    .mem_rdata      (mem_rdata),
    .fill_rvalid    (fill_rvalid),
    .fill_rdata     (fill_rdata)
  );

endmodule

`default_nettype wire

/* tb/offchip_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module offchip_mem_model import mem_pkg::*; (
  input  wire           clk,
  input  wire           arst_n,
  input  wire mem_req_t mem_req,
  output logic          mem_data_valid,   // One cycle per read
  output word_t         mem_rdata
);

  localparam int MEM_WORDS = 1 << ADDR_W;

  word_t      mem [MEM_WORDS];
  logic       pending;                     // Read accepted, data not yet back
  logic [1:0] wait_q;                      // Cycles left before the data
  addr_t      rd_addr;

  // Every word starts as its address scrambled
  initial begin
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = word_t'(a) ^ 16'hA5A5;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reads, latency of 1 to 4 cycles
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending        <= 1'b0;
      wait_q         <= '0;
      rd_addr        <= '0;
      mem_data_valid <= 1'b0;
      mem_rdata      <= '0;
    end else begin
      mem_data_valid <= 1'b0;
      if (pending) begin
        if (wait_q == 2'd0) begin
          mem_data_valid <= 1'b1;
          mem_rdata      <= mem[rd_addr];
          pending        <= 1'b0;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end else if (mem_req.en && !mem_req.wr && !mem_data_valid) begin
        // En is still up during the data cycle, that read is already served
        pending <= 1'b1;
        rd_addr <= mem_req.addr;
        wait_q  <= 2'($urandom_range(3, 0));
      end
    end
  end

  // Writes land at once
  always @(posedge clk) begin
    if (mem_req.en && mem_req.wr) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
  end

endmodule

`default_nettype wire

/* tb/mem_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_checker import mem_pkg::*; (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             i_req_valid,
  input  wire addr_t      i_req_addr,
  input  wire             i_ready,
  input  wire word_t      i_rdata,
  input  wire             d_req_valid,
  input  wire cache_req_t d_req,
  input  wire             d_ready,
  input  wire word_t      d_rdata,
  input  wire mem_req_t   mem_req,
  output int              err_cnt,
  output int              i_done_cnt,     // Fetch handshakes seen
  output int              d_done_cnt      // Data handshakes seen
);

  word_t shadow [addr_t];                 // Words written through the data cache
  logic  i_wait;
  logic  d_wait;
  logic  i_wait_q;
  logic  d_wait_q;
  logic  i_first;                         // Fetch block owns the port after a tie

  // Expected word at an address
  function automatic word_t expected_word(input addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return a ^ 16'hA5A5;
  endfunction

  assign i_wait = i_req_valid && !i_ready;
  assign d_wait = d_req_valid && !d_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Compare on every rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    int    errs;
    word_t exp_w;
    errs = 0;
    if (!arst_n) begin
      err_cnt    <= 0;
      i_done_cnt <= 0;
      d_done_cnt <= 0;
      i_wait_q   <= 1'b0;
      d_wait_q   <= 1'b0;
      i_first    <= 1'b0;
      shadow.delete();
    end else begin
      if (mem_req.en && !i_req_valid && !d_req_valid) begin
        $display("ERROR: off-chip access at %0t with no request pending", $time);
        errs++;
      end
      if ((i_ready && !i_req_valid) || (d_ready && !d_req_valid)) begin
        $display("ERROR: cache ready at %0t with no request pending", $time);
        errs++;
      end
      if (mem_req.en && mem_req.wr && !(d_req_valid && d_ready && d_req.wr)) begin
        $display("ERROR: off-chip write at %0t without a data write handshake", $time);
        errs++;
      end
      if (i_req_valid && i_ready) begin
        i_done_cnt <= i_done_cnt + 1;
        exp_w = expected_word(i_req_addr);
        if (i_rdata !== exp_w) begin
          $display("FAIL i_rdata addr %h: expected %h, got %h", i_req_addr, exp_w, i_rdata);
          errs++;
        end
      end
      if (d_req_valid && d_ready) begin
        d_done_cnt <= d_done_cnt + 1;
        if (d_req.wr) begin
          if (!(mem_req.en && mem_req.wr)) begin
            $display("ERROR: data write at %h accepted without a write-through", d_req.addr);
            errs++;
          end else begin
            if (mem_req.addr !== d_req.addr) begin
              $display("FAIL mem_req.addr: expected %h, got %h", d_req.addr, mem_req.addr);
              errs++;
            end
            if (mem_req.wdata !== d_req.wdata) begin
              $display("FAIL mem_req.wdata: expected %h, got %h", d_req.wdata, mem_req.wdata);
              errs++;
            end
          end
          shadow[d_req.addr] = d_req.wdata;   // Visible to later reads
        end else begin
          exp_w = expected_word(d_req.addr);
          if (d_rdata !== exp_w) begin
            $display("FAIL d_rdata addr %h: expected %h, got %h", d_req.addr, exp_w, d_rdata);
            errs++;
          end
        end
      end
      // Both caches start missing together so the fetch side owns the port first
      if (i_wait && d_wait && !i_wait_q && !d_wait_q) begin
        i_first <= 1'b1;
      end else if (i_req_valid && i_ready) begin
        i_first <= 1'b0;
      end
      if (i_first && mem_req.en && !mem_req.wr && mem_req.addr >= 16'h8000) begin
        $display("ERROR: data block read at %h before the fetch fill ended", mem_req.addr);
        errs++;
      end
      i_wait_q <= i_wait;
      d_wait_q <= d_wait;
      err_cnt  <= err_cnt + errs;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top import mem_pkg::*; ();

  localparam int N_RAND     = 100;                  // Per stream, two streams
  localparam int N_REQ      = 7 + 2 * N_RAND;
  localparam int TIMEOUT_NS = N_REQ * BLOCK_WORDS * 6 * 20 + 50000;

  logic       clk;
  logic       arst_n;
  logic       i_req_valid;
  addr_t      i_req_addr;
  logic       i_ready;
  word_t      i_rdata;
  logic       d_req_valid;
  cache_req_t d_req;
  logic       d_ready;
  word_t      d_rdata;
  mem_req_t   mem_req;
  logic       mem_data_valid;
  word_t      mem_rdata;
  logic       i_fire_q;                 // Handshake at the last rising edge
  logic       d_fire_q;
  int         err_cnt;
  int         i_done_cnt;
  int         d_done_cnt;
  int         tb_errs;
  int         i_sent;
  int         d_sent;

  mem_hier_top i_mem_hier_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .i_req_valid    (i_req_valid),
    .i_req_addr     (i_req_addr),
    .i_ready        (i_ready),
    .i_rdata        (i_rdata),
    .d_req_valid    (d_req_valid),
    .d_req          (d_req),
    .d_ready        (d_ready),
    .d_rdata        (d_rdata),
    .mem_req        (mem_req),
    .mem_data_valid (mem_data_valid),
    .mem_rdata      (mem_rdata)
  );

  offchip_mem_model i_offchip_mem_model (
    .clk            (clk),
    .arst_n         (arst_n),
    .mem_req        (mem_req),
    .mem_data_valid (mem_data_valid),
    .mem_rdata      (mem_rdata)
  );

  mem_checker i_mem_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .i_req_valid (i_req_valid),
    .i_req_addr  (i_req_addr),
    .i_ready     (i_ready),
    .i_rdata     (i_rdata),
    .d_req_valid (d_req_valid),
    .d_req       (d_req),
    .d_ready     (d_ready),
    .d_rdata     (d_rdata),
    .mem_req     (mem_req),
    .err_cnt     (err_cnt),
    .i_done_cnt  (i_done_cnt),
    .d_done_cnt  (d_done_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                 // 20 ns period
  end

  // Tasks read these on falling edges, well away from the update
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      i_fire_q <= 1'b0;
      d_fire_q <= 1'b0;
    end else begin
      i_fire_q <= i_req_valid && i_ready;
      d_fire_q <= d_req_valid && d_ready;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Requesters, entered and left on a falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic fetch(input addr_t a);
    i_req_valid = 1'b1;
    i_req_addr  = a;
    i_sent++;
    do @(negedge clk); while (!i_fire_q);   // Hold until accepted
    i_req_valid = 1'b0;
  endtask

  task automatic data_access(input logic wr, input addr_t a, input word_t wd);
    d_req_valid = 1'b1;
    d_req       = '{addr: a, wdata: wd, wr: wr};
    d_sent++;
    do @(negedge clk); while (!d_fire_q);
    d_req_valid = 1'b0;
  endtask

  // Four tags per set, so blocks keep evicting each other
  function automatic addr_t rand_fetch_addr();
    return {9'd0, 2'($urandom_range(3, 0)), 5'($urandom_range(31, 0))};
  endfunction

  function automatic addr_t rand_data_addr();
    return {1'b1, 8'd0, 2'($urandom_range(3, 0)), 5'($urandom_range(31, 0))};
  endfunction

  task automatic fetch_stream(input int n);
    int gap;
    for (int k = 0; k < n; k++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) @(negedge clk);
      fetch(rand_fetch_addr());
    end
  endtask

  task automatic data_stream(input int n);
    int   gap;
    logic wr;
    for (int k = 0; k < n; k++) begin
      gap = $urandom_range(2, 0);
      wr  = ($urandom_range(9, 0) < 4);       // About 40 percent writes
      repeat (gap) @(negedge clk);
      data_access(wr, rand_data_addr(), word_t'($urandom()));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(18432));
    arst_n      = 1'b0;
    i_req_valid = 1'b0;
    i_req_addr  = '0;
    d_req_valid = 1'b0;
    d_req       = '0;
    tb_errs     = 0;
    i_sent      = 0;
    d_sent      = 0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    repeat (6) @(negedge clk);               // Idle, port and ready stay low
    fetch(16'h0123);                          // Cold miss
    fetch(16'h0123);                          // Same word, now a hit
    data_access(1'b1, 16'h8010, 16'h1234);    // Write miss, fill then write
    data_access(1'b0, 16'h8010, '0);
    data_access(1'b0, 16'h8011, '0);          // Neighbour keeps memory value
    fork                                      // Both miss on set 0 together
      fetch(16'h0200);
      data_access(1'b0, 16'h9040, '0);
    join
    fork
      fetch_stream(N_RAND);
      data_stream(N_RAND);
    join
    repeat (4) @(negedge clk);
    if (i_done_cnt != i_sent || d_done_cnt != d_sent) begin
      $display("ERROR: checker saw %0d/%0d handshakes, %0d/%0d were sent",
               i_done_cnt, d_done_cnt, i_sent, d_sent);
      tb_errs++;
    end
    $display("Errors: %0d (checker %0d, testbench %0d), fetches %0d, data accesses %0d",
             err_cnt + tb_errs, err_cnt, tb_errs, i_done_cnt, d_done_cnt);
    if (err_cnt + tb_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog, scaled to the worst case fill of every request
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: run did not finish within %0d ns, stuck waiting for a handshake",
             TIMEOUT_NS);
    $display("Errors: %0d (checker %0d, testbench %0d), fetches %0d, data accesses %0d",
             err_cnt + tb_errs + 1, err_cnt, tb_errs + 1, i_done_cnt, d_done_cnt);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/mem_pkg.sv
verilog/cache_array.sv
verilog/cache_fill_fsm.sv
verilog/cache_unit.sv
verilog/mem_arbiter.sv
verilog/mem_hier_top.sv
tb/offchip_mem_model.sv
tb/mem_checker.sv
tb/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_top -Mdir obj_dir -o tb_top_sim -f all.f

./obj_dir/tb_top_sim | tee sim.log

if grep -q '^Result: PASSED$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
